// ==== mccu_defines.svh ====
`ifndef MCCU_DEFINES_SVH
`define MCCU_DEFINES_SVH

// ---------------------------------------------------------------------------
// Contention control unit sizing
// ---------------------------------------------------------------------------

// Number of monitored cores
`define MCCU_N_CORES 2

// Contention events reported by each core per cycle
`define MCCU_CORE_EVENTS 4

// Width of one core's quota register
`define MCCU_QUOTA_W 32

// Width of a single worst-case event weight
`define MCCU_WEIGHT_W 8

// Consumed sum is kept at double quota width so it never wraps
`define MCCU_SUM_W (2 * `MCCU_QUOTA_W)

`endif

// ==== mccu_event_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mccu_defines.svh"

// Stage one of the contention pipeline
// Turns each core's event vector into the contention consumed this cycle
module mccu_event_accumulator
    import mccu_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    // Events seen by each core this cycle
    input  wire core_events_t  events_i  [`MCCU_N_CORES],
    // Software worst-case weights, already registered outside
    input  wire core_weights_t weights_i [`MCCU_N_CORES],
    // Registered per-core consumed sums towards quota tracking
    output ccc_stage_t         ccc_o
);

    // ------------------------------------------------------------------------
    // Event masking
    // ------------------------------------------------------------------------

    // Weight of each event, forced to zero when the event is idle
    weight_t    masked_w [`MCCU_N_CORES][`MCCU_CORE_EVENTS];
    // Combinational sum before the stage register
    ccc_stage_t ccc_d;

    always_comb begin
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            for (int e = 0; e < `MCCU_CORE_EVENTS; e++) begin
                // Inactive event contributes nothing
                masked_w[c][e] = events_i[c][e] ? weights_i[c].w[e] : '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Per-core addition
    // ------------------------------------------------------------------------

    always_comb begin
        ccc_d = '0;
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            // Extend every weight to sum width before adding
            for (int e = 0; e < `MCCU_CORE_EVENTS; e++) begin
                ccc_d.sum[c] = ccc_d.sum[c] + ccc_sum_t'(masked_w[c][e]);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------

    // Sums are taken every cycle, enabled or not
    // Quota tracking decides whether they are charged
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ccc_o <= '0;
        end else begin
            ccc_o <= ccc_d;
        end
    end

endmodule

`default_nettype wire

// ==== mccu_pkg.sv ====
`default_nettype none

`include "mccu_defines.svh"

package mccu_pkg;

    // -----------------------------------------------------------------------
    // Scalar data types
    // -----------------------------------------------------------------------

    // Remaining quota of one core
    typedef logic [`MCCU_QUOTA_W-1:0] quota_t;
    // Worst-case contention of one event
    typedef logic [`MCCU_WEIGHT_W-1:0] weight_t;
    // Contention consumed by one core in one cycle
    typedef logic [`MCCU_SUM_W-1:0] ccc_sum_t;
    // Active events of one core, one bit per event
    typedef logic [`MCCU_CORE_EVENTS-1:0] core_events_t;

    // -----------------------------------------------------------------------
    // Per-core bundles
    // -----------------------------------------------------------------------

    // Weights of all events of one core, index matches the event bit
    typedef struct packed {
        weight_t [`MCCU_CORE_EVENTS-1:0] w;
    } core_weights_t;

    // Software quota load request
    typedef struct packed {
        logic   load;
        quota_t quota;
    } quota_cfg_t;

    // Consumed sums handed from accumulation to quota tracking
    typedef struct packed {
        ccc_sum_t [`MCCU_N_CORES-1:0] sum;
    } ccc_stage_t;

    // Per-core quota update, encoded as {enable, load}
    typedef enum logic [1:0] {
        QM_HOLD         = 2'b00,
        QM_LOAD         = 2'b01,
        QM_CONSUME      = 2'b10,
        QM_LOAD_CONSUME = 2'b11
    } quota_mode_e;

endpackage

`default_nettype wire

// ==== mccu_quota_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mccu_defines.svh"

// Stage two of the contention pipeline
// Holds the per-core quota, charges the consumed sums and raises overrun irqs
module mccu_quota_tracker
    import mccu_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    // Charging and interrupts only happen while enabled
    input  wire logic                     enable_i,
    // Sums registered by the accumulator one cycle earlier
    input  wire ccc_stage_t               ccc_i,
    // Software quota loads, may coincide with charging
    input  wire quota_cfg_t               quota_cfg_i [`MCCU_N_CORES],
    // Remaining quota per core
    output quota_t                        quota_o     [`MCCU_N_CORES],
    // Sticky overrun interrupt per core
    output logic [`MCCU_N_CORES-1:0]      irq_quota_o
);

    // Quota registers
    quota_t                   quota_q [`MCCU_N_CORES];
    quota_t                   quota_d [`MCCU_N_CORES];
    // Update decision per core
    quota_mode_e              mode    [`MCCU_N_CORES];
    // Quota the charge is taken from, loaded or held
    quota_t                   base    [`MCCU_N_CORES];
    // Base minus sum, saturated at zero
    quota_t                   charged [`MCCU_N_CORES];
    // Sum beyond the quota held before the edge
    logic [`MCCU_N_CORES-1:0] overrun;
    // Sticky interrupt registers
    logic [`MCCU_N_CORES-1:0] irq_q;

    // ------------------------------------------------------------------------
    // Mode decode and saturating charge
    // ------------------------------------------------------------------------

    always_comb begin
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            mode[c] = quota_mode_e'({enable_i, quota_cfg_i[c].load});

            // New quota bypasses the register on a load
            base[c] = quota_cfg_i[c].load ? quota_cfg_i[c].quota : quota_q[c];

            // Compare at full sum width, upper sum bits mean a sure underflow
            if (ccc_i.sum[c] > ccc_sum_t'(base[c])) begin
                charged[c] = '0;
            end else begin
                charged[c] = base[c] - ccc_i.sum[c][`MCCU_QUOTA_W-1:0];
            end
        end
    end

    // Next quota value per mode
    always_comb begin
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            unique case (mode[c])
                QM_HOLD:         quota_d[c] = quota_q[c];
                QM_LOAD:         quota_d[c] = quota_cfg_i[c].quota;
                QM_CONSUME:      quota_d[c] = charged[c];
                QM_LOAD_CONSUME: quota_d[c] = charged[c];
                default:         quota_d[c] = quota_q[c];
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < `MCCU_N_CORES; c++) begin
                quota_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < `MCCU_N_CORES; c++) begin
                quota_q[c] <= quota_d[c];
            end
        end
    end

    assign quota_o = quota_q;

    // ------------------------------------------------------------------------
    // Overrun interrupt
    // ------------------------------------------------------------------------

    // Against the held quota only, a load this cycle does not mask an overrun
    always_comb begin
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            overrun[c] = ccc_i.sum[c] > ccc_sum_t'(quota_q[c]);
        end
    end

    // Set on overrun while enabled, stays set until the unit is disabled
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            irq_q <= '0;
        end else if (enable_i) begin
            irq_q <= irq_q | overrun;
        end else begin
            irq_q <= '0;
        end
    end

    // Drop the line at once when disabled or held in reset
    assign irq_quota_o = (enable_i && rstn_i) ? irq_q : '0;

endmodule

`default_nettype wire

// ==== mccu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mccu_defines.svh"

// Maximum-contention control unit
// Events sampled at one edge are charged to the quota at the next edge
module mccu_top
    import mccu_pkg::*;
(
    input  wire logic                     clk_i,
    // Synchronous, active low
    input  wire logic                     rstn_i,
    // Allows charging and interrupts
    input  wire logic                     enable_i,
    // Contention events per core
    input  wire core_events_t             events_i    [`MCCU_N_CORES],
    // Worst-case event weights per core
    input  wire core_weights_t            weights_i   [`MCCU_N_CORES],
    // Quota load requests per core
    input  wire quota_cfg_t               quota_cfg_i [`MCCU_N_CORES],
    // Remaining quota per core
    output quota_t                        quota_o     [`MCCU_N_CORES],
    // Quota overrun interrupt per core
    output logic [`MCCU_N_CORES-1:0]      irq_quota_o
);

    // ------------------------------------------------------------------------
    // Pipeline link
    // ------------------------------------------------------------------------

    // Registered consumed sums, one per core
    ccc_stage_t ccc_stage;

    // ------------------------------------------------------------------------
    // Stage one, event accumulation
    // ------------------------------------------------------------------------

    mccu_event_accumulator u_event_accumulator (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .events_i  (events_i),
        .weights_i (weights_i),
        .ccc_o     (ccc_stage)
    );

    // ------------------------------------------------------------------------
    // Stage two, quota tracking
    // ------------------------------------------------------------------------

    mccu_quota_tracker u_quota_tracker (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .enable_i    (enable_i),
        .ccc_i       (ccc_stage),
        .quota_cfg_i (quota_cfg_i),
        .quota_o     (quota_o),
        .irq_quota_o (irq_quota_o)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module tb_mccu -o tb_mccu &&
./obj_dir/tb_mccu ||
exit 1

// ==== sim.f ====
+incdir+.
mccu_pkg.sv
mccu_event_accumulator.sv
mccu_quota_tracker.sv
mccu_top.sv
tb_mccu.sv

// ==== tb_mccu_table.svh ====
`ifndef TB_MCCU_TABLE_SVH
`define TB_MCCU_TABLE_SVH

// ---------------------------------------------------------------------------
// Directed steps for two cores
// ---------------------------------------------------------------------------

localparam int TABLE_ROWS = 16;

// Columns: enable, load {c1,c0}, quota c0, quota c1, events c0, events c1,
// weights c0, weights c1 {w3,w2,w1,w0}, expected quota c0, c1, irq {c1,c0}
task automatic load_table();
    // Idle after reset
    add_row(1'b0, 2'b00, 32'd0, 32'd0, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd0, 32'd0, 2'b00);
    // Load both cores while disabled
    add_row(1'b0, 2'b11, 32'd100, 32'd200, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd100, 32'd200, 2'b00);
    // Events while disabled, sums 10 and 70 are never charged
    add_row(1'b0, 2'b00, 32'd0, 32'd0, 4'hF, 4'h3, 32'h0102_0304, 32'h0A14_1E28,
            32'd100, 32'd200, 2'b00);
    add_row(1'b0, 2'b00, 32'd0, 32'd0, 4'h0, 4'h0, 32'h0102_0304, 32'h0A14_1E28,
            32'd100, 32'd200, 2'b00);
    // Enable, sums 10 and 70 enter the pipe
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'hF, 4'h3, 32'h0102_0304, 32'h0A14_1E28,
            32'd100, 32'd200, 2'b00);
    // Charge 10/70, next sums 6 and 5 (zero weights on active events)
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'h5, 4'hF, 32'h0102_0304, 32'h0000_0005,
            32'd90, 32'd130, 2'b00);
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd84, 32'd125, 2'b00);
    // Core 0 reloads 3000, next sums 1020 and 25
    add_row(1'b1, 2'b01, 32'd3000, 32'd0, 4'hF, 4'h1, 32'hFFFF_FFFF, 32'h0000_0019,
            32'd3000, 32'd125, 2'b00);
    // Load 2000 together with the pending 1020
    add_row(1'b1, 2'b01, 32'd2000, 32'd0, 4'h0, 4'h1, 32'h0, 32'h0000_0019,
            32'd980, 32'd100, 2'b00);
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'hF, 4'h0, 32'hFFFF_FFFF, 32'h0,
            32'd980, 32'd75, 2'b00);
    // 1020 over 980 saturates core 0 and raises its irq
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd0, 32'd75, 2'b01);
    // Irq is sticky across a reload
    add_row(1'b1, 2'b01, 32'd500, 32'd0, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd500, 32'd75, 2'b01);
    // Disable clears it
    add_row(1'b0, 2'b00, 32'd0, 32'd0, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd500, 32'd75, 2'b00);
    // Core 1 sum of exactly 75
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'h0, 4'h3, 32'h0, 32'h0000_2328,
            32'd500, 32'd75, 2'b00);
    // Equal sum empties the quota without an overrun
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd500, 32'd0, 2'b00);
    add_row(1'b1, 2'b00, 32'd0, 32'd0, 4'h0, 4'h0, 32'h0, 32'h0,
            32'd500, 32'd0, 2'b00);
endtask

`endif

// ==== tb_mccu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mccu_defines.svh"

// Testbench for the maximum-contention control unit
// Runs the directed table and then LFSR traffic checked against a reference model
module tb_mccu
    import mccu_pkg::*;
();

    localparam int CYCLE_NS     = 100;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 200;
    localparam int SLACK_CYCLES = 10;

    // One directed step for both cores with index 0 as core 0
    typedef struct packed {
        logic                             en;
        logic [`MCCU_N_CORES-1:0]         ld;
        quota_t [`MCCU_N_CORES-1:0]       q;
        core_events_t [`MCCU_N_CORES-1:0] ev;
        core_weights_t [`MCCU_N_CORES-1:0] w;
        quota_t [`MCCU_N_CORES-1:0]       exp_q;
        logic [`MCCU_N_CORES-1:0]         exp_irq;
    } row_t;

`include "tb_mccu_table.svh"

    // ------------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------------

    logic                     clk_i = 1'b0;
    logic                     rstn_i;
    logic                     enable_i;
    core_events_t             events    [`MCCU_N_CORES];
    core_weights_t            weights   [`MCCU_N_CORES];
    quota_cfg_t               quota_cfg [`MCCU_N_CORES];
    quota_t                   quota     [`MCCU_N_CORES];
    logic [`MCCU_N_CORES-1:0] irq_quota;

    // Directed table storage
    row_t rows [TABLE_ROWS];
    int   row_cnt = 0;

    // Reference model state
    ccc_sum_t                 m_sum   [`MCCU_N_CORES];
    quota_t                   m_quota [`MCCU_N_CORES];
    logic [`MCCU_N_CORES-1:0] m_irq;
    logic [31:0]              lfsr_state;

    mccu_top uut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .enable_i    (enable_i),
        .events_i    (events),
        .weights_i   (weights),
        .quota_cfg_i (quota_cfg),
        .quota_o     (quota),
        .irq_quota_o (irq_quota)
    );

    always #(CYCLE_NS / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic add_row(input logic en, input logic [1:0] ld,
                           input quota_t q0, input quota_t q1,
                           input core_events_t ev0, input core_events_t ev1,
                           input core_weights_t w0, input core_weights_t w1,
                           input quota_t eq0, input quota_t eq1,
                           input logic [1:0] eirq);
        rows[row_cnt].en      = en;
        rows[row_cnt].ld      = ld;
        rows[row_cnt].q       = {q1, q0};
        rows[row_cnt].ev      = {ev1, ev0};
        rows[row_cnt].w       = {w1, w0};
        rows[row_cnt].exp_q   = {eq1, eq0};
        rows[row_cnt].exp_irq = eirq;
        row_cnt++;
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_quota(input int core, input quota_t exp_v, input quota_t act_v);
        if (exp_v !== act_v) begin
            $display("ERROR at %0t ns: core %0d quota expected %0d, got %0d",
                     $time, core, exp_v, act_v);
            $display("RESULT: FAIL");
            $fatal(1, "quota mismatch");
        end
    endtask

    task automatic check_irq(input int core, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            $display("ERROR at %0t ns: core %0d irq expected %0b, got %0b",
                     $time, core, exp_v, act_v);
            $display("RESULT: FAIL");
            $fatal(1, "interrupt mismatch");
        end
    endtask

    // Interrupt line right after new inputs, before the next edge
    // The held sticky bit only shows while enable_i is high
    task automatic check_irq_gate();
        #1;
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            check_irq(c, enable_i & m_irq[c], irq_quota[c]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model stepped once per rising edge
    // ------------------------------------------------------------------------

    task automatic model_step();
        quota_mode_e mode;
        quota_t      base;
        ccc_sum_t    sum_next;
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            mode = quota_mode_e'({enable_i, quota_cfg[c].load});
            // Overrun judged against the quota before this edge
            if (enable_i) begin
                m_irq[c] = m_irq[c] | (m_sum[c] > ccc_sum_t'(m_quota[c]));
            end else begin
                m_irq[c] = 1'b0;
            end
            base = quota_cfg[c].load ? quota_cfg[c].quota : m_quota[c];
            case (mode)
                QM_LOAD: m_quota[c] = quota_cfg[c].quota;
                QM_CONSUME, QM_LOAD_CONSUME: begin
                    if (m_sum[c] > ccc_sum_t'(base)) begin
                        m_quota[c] = '0;
                    end else begin
                        m_quota[c] = base - quota_t'(m_sum[c]);
                    end
                end
                default: m_quota[c] = m_quota[c];
            endcase
            // Sum of this cycle is charged at the next edge
            sum_next = '0;
            for (int e = 0; e < `MCCU_CORE_EVENTS; e++) begin
                if (events[c][e]) begin
                    sum_next = sum_next + ccc_sum_t'(weights[c].w[e]);
                end
            end
            m_sum[c] = sum_next;
        end
    endtask

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------

    initial begin
        #(CYCLE_NS * (RESET_CYCLES + TABLE_ROWS + RAND_CYCLES + SLACK_CYCLES));
        $display("Simulation timed out before all tests finished");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        rstn_i     = 1'b0;
        enable_i   = 1'b0;
        lfsr_state = 32'd48;
        m_irq      = '0;
        for (int c = 0; c < `MCCU_N_CORES; c++) begin
            events[c]    = '0;
            weights[c]   = '0;
            quota_cfg[c] = '0;
            m_sum[c]     = '0;
            m_quota[c]   = '0;
        end
        load_table();

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        // Directed rows with outputs checked one edge after the row is applied
        for (int r = 0; r < TABLE_ROWS; r++) begin
            enable_i = rows[r].en;
            for (int c = 0; c < `MCCU_N_CORES; c++) begin
                quota_cfg[c].load  = rows[r].ld[c];
                quota_cfg[c].quota = rows[r].q[c];
                events[c]          = rows[r].ev[c];
                weights[c]         = rows[r].w[c];
            end
            check_irq_gate();
            @(posedge clk_i);
            model_step();
            @(negedge clk_i);
            for (int c = 0; c < `MCCU_N_CORES; c++) begin
                check_quota(c, rows[r].exp_q[c], quota[c]);
                check_irq(c, rows[r].exp_irq[c], irq_quota[c]);
            end
        end

        // Random traffic that is mostly enabled with occasional small quota loads
        for (int n = 0; n < RAND_CYCLES; n++) begin
            enable_i = (rand_bits(3) != 32'd0);
            for (int c = 0; c < `MCCU_N_CORES; c++) begin
                quota_cfg[c].load  = (rand_bits(3) == 32'd7);
                quota_cfg[c].quota = quota_t'(rand_bits(11));
                events[c]          = core_events_t'(rand_bits(`MCCU_CORE_EVENTS));
                for (int e = 0; e < `MCCU_CORE_EVENTS; e++) begin
                    weights[c].w[e] = weight_t'(rand_bits(`MCCU_WEIGHT_W));
                end
            end
            check_irq_gate();
            @(posedge clk_i);
            model_step();
            @(negedge clk_i);
            for (int c = 0; c < `MCCU_N_CORES; c++) begin
                check_quota(c, m_quota[c], quota[c]);
                check_irq(c, enable_i & m_irq[c], irq_quota[c]);
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
